/* bench/keypad_calc_tb.sv */
`timescale 1ns/1ps

module keypad_calc_tb
    import keypad_pkg::*;
    import calc_pkg::*;
();

    localparam int PRESS_TIMEOUT   = 400;                  // Clocks a key is held at most
    localparam int REV_CYCLES      = 4 * SCAN_TICK_CYCLES; // One keypad revolution
    localparam int DISPLAY_TIMEOUT = 3 * NUM_DIGITS * DIGIT_TICK_CYCLES;

    // Active-low gfedcba patterns with a tail-less nine
    localparam seg_t DIGIT_SEGS [10] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0011000
    };

    logic        clk;
    logic        rst;
    col_t        cols     = '0;
    row_t        rows;
    seg_t        seg;
    anode_t      an;
    logic        key_down = 1'b0;
    logic [1:0]  held_row = '0;
    logic [1:0]  held_col = '0;
    int          cycle_cnt = 0;

    // Calculator model
    calc_state_e m_state;
    int          m_a;
    int          m_b;
    logic        m_mul;
    int          m_shown;

    tb_clock i_tb_clock (
        .clk (clk)
    );

    keypad_calc i_dut (
        .clk  (clk),
        .rst  (rst),
        .cols (cols),
        .rows (rows),
        .seg  (seg),
        .an   (an)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // The held key closes its column while its row is driven
    always @(posedge clk) begin
        if (key_down && rows[held_row]) begin
            cols <= col_t'(1) << held_col;
        end else begin
            cols <= '0;
        end
    end

    // ******************************
    // Helpers
    // ******************************
    function automatic logic [3:0] key_position(input key_code_t code);
        case (code)  // {row, column}
            4'd1:    return 4'b00_00;
            4'd2:    return 4'b00_01;
            4'd3:    return 4'b00_10;
            4'd10:   return 4'b00_11;
            4'd4:    return 4'b01_00;
            4'd5:    return 4'b01_01;
            4'd6:    return 4'b01_10;
            4'd11:   return 4'b01_11;
            4'd7:    return 4'b10_00;
            4'd8:    return 4'b10_01;
            4'd9:    return 4'b10_10;
            4'd12:   return 4'b10_11;
            4'd14:   return 4'b11_00;
            4'd0:    return 4'b11_01;
            4'd15:   return 4'b11_10;
            default: return 4'b11_11;  // D
        endcase
    endfunction

    function automatic int segments_to_digit(input seg_t pattern);
        for (int d = 0; d < 10; d++) begin
            if (DIGIT_SEGS[d] == pattern) begin
                return d;
            end
        end
        return -1;
    endfunction

    function automatic int anode_to_slot(input anode_t enables);
        case (enables)
            4'b1110: return 0;
            4'b1101: return 1;
            4'b1011: return 2;
            4'b0111: return 3;
            default: return -1;  // Blank or more than one lit
        endcase
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            abort_run($sformatf("FAIL time=%0t %s: got %0d, expected %0d",
                                $time, name, got, expected));
        end
    endtask

    task automatic read_display(output int value);
        int       dig [4];
        bit [3:0] seen;
        int       cycles;
        int       slot;
        int       d;
        seen   = '0;
        cycles = 0;
        while (seen != 4'hF) begin
            @(negedge clk);
            cycles++;
            if (cycles > DISPLAY_TIMEOUT) begin
                abort_run("Timed out waiting for all four display digits to be lit");
            end
            slot = anode_to_slot(an);
            if (slot >= 0) begin
                d = segments_to_digit(seg);
                if (d < 0) begin
                    abort_run($sformatf("Unknown segment pattern %b on digit %0d", seg, slot));
                end
                dig[slot]  = d;
                seen[slot] = 1'b1;
            end
        end
        value = dig[3] * 1000 + dig[2] * 100 + dig[1] * 10 + dig[0];
    endtask

    task automatic wait_revolutions(input int n);
        int   count;
        int   cycles;
        logic last_row;
        count    = 0;
        cycles   = 0;
        last_row = 1'b0;
        while (count < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > (n + 1) * REV_CYCLES) begin
                abort_run("Timed out waiting for the keypad scan to complete revolutions");
            end
            if (rows == 4'b0001 && last_row) begin
                count++;
            end
            last_row = (rows == 4'b1000);
        end
    endtask

    task automatic press_key(input key_code_t code, input int expected, input logic changes);
        logic [3:0] pos;
        int         t0;
        int         got;
        pos = key_position(code);
        @(posedge clk);
        t0 = cycle_cnt;
        held_row <= pos[3:2];
        held_col <= pos[1:0];
        key_down <= 1'b1;
        if (changes) begin
            got = -1;
            while (got != expected && cycle_cnt - t0 < PRESS_TIMEOUT) begin
                read_display(got);
            end
        end else begin
            while (cycle_cnt - t0 < PRESS_TIMEOUT) begin  // Nothing visible to wait for
                @(posedge clk);
            end
        end
        @(posedge clk);
        key_down <= 1'b0;
        wait_revolutions(5);
    endtask

    // Entry rules of the calculator
    task automatic model_key(input key_code_t code);
        if (code <= 4'd9) begin
            if (m_state == ENTER_B) begin
                m_b     = (m_b * 10 + int'(code)) % 100;
                m_shown = m_b;
            end else begin
                m_a     = (m_state == RESULT) ? int'(code) : (m_a * 10 + int'(code)) % 100;
                m_state = ENTER_A;
                m_shown = m_a;
            end
        end else if (code == KEY_CLR) begin
            m_a     = 0;
            m_b     = 0;
            m_shown = 0;
            m_state = ENTER_A;
        end else if ((code == KEY_ADD || code == KEY_MUL) && m_state == ENTER_A) begin
            m_mul   = (code == KEY_MUL);
            m_b     = 0;
            m_state = ENTER_B;
        end else if (code == KEY_EQ && m_state == ENTER_B) begin
            m_shown = m_mul ? m_a * m_b : m_a + m_b;
            m_state = RESULT;
        end
    endtask

    task automatic enter_key(input key_code_t code);
        int prev;
        int got;
        prev = m_shown;
        model_key(code);
        press_key(code, m_shown, m_shown != prev);
        read_display(got);
        check_value($sformatf("display after key %0d", code), got, m_shown);
    endtask

    task automatic enter_number(input int value);
        enter_key(key_code_t'(value / 10));
        enter_key(key_code_t'(value % 10));
    endtask

    task automatic reset_dut();
        m_state = ENTER_A;
        m_a     = 0;
        m_b     = 0;
        m_mul   = 1'b0;
        m_shown = 0;
        @(posedge clk);
        @(negedge clk);
        check_value("rows in reset", rows, 1);
        check_value("an in reset", an, 15);
        @(posedge clk);
        rst <= 1'b0;
    endtask

    // ******************************
    // Directed tests
    // ******************************
    task automatic reset_state_display();
        int got;
        read_display(got);
        check_value("display after reset", got, 0);
        for (int i = 0; i < 2 * REV_CYCLES; i++) begin
            @(negedge clk);
            check_value("active rows", $countones(rows), 1);
        end
    endtask

    task automatic digit_entry_keeps_two();
        int got;
        enter_key(4'd4);
        enter_key(4'd2);
        read_display(got);
        check_value("display", got, 42);
        enter_key(4'd7);  // Oldest digit drops out
        read_display(got);
        check_value("display", got, 27);
    endtask

    task automatic addition_result();
        int got;
        enter_number(42);
        enter_key(KEY_ADD);
        enter_number(58);
        enter_key(KEY_EQ);
        read_display(got);
        check_value("sum", got, 100);
    endtask

    task automatic multiplication_results();
        int ra;
        int rb;
        int got;
        enter_number(99);
        enter_key(KEY_MUL);
        enter_number(99);
        enter_key(KEY_EQ);
        read_display(got);
        check_value("product", got, 9801);
        for (int i = 0; i < 8; i++) begin
            ra = $urandom % 100;
            rb = $urandom % 100;
            enter_number(ra);
            enter_key(KEY_MUL);
            enter_number(rb);
            enter_key(KEY_EQ);
            read_display(got);
            check_value($sformatf("product %0d*%0d", ra, rb), got, ra * rb);
        end
    endtask

    task automatic ignored_and_clear_keys();
        int got;
        enter_key(4'd5);
        enter_key(4'd14);
        enter_key(4'd15);
        enter_key(KEY_EQ);  // No operation chosen yet
        read_display(got);
        check_value("display after ignored keys", got, 5);
        enter_key(KEY_CLR);
        enter_key(KEY_MUL);
        enter_key(KEY_EQ);
        read_display(got);
        check_value("product of zeros", got, 0);
    endtask

    task automatic fresh_entry_after_result();
        int got;
        enter_key(4'd8);
        enter_key(KEY_ADD);
        enter_key(4'd9);
        enter_key(KEY_EQ);
        enter_key(4'd6);
        read_display(got);
        check_value("fresh digit", got, 6);
        enter_key(KEY_MUL);
        enter_key(4'd0);
        enter_key(KEY_EQ);
        read_display(got);
        check_value("times zero", got, 0);
        enter_key(4'd3);
        enter_key(KEY_ADD);
        enter_key(4'd4);
        enter_key(KEY_EQ);
        read_display(got);
        check_value("sum after result", got, 7);
    endtask

    initial begin
        rst = 1'b1;
        void'($urandom(82));
        reset_dut();
        reset_state_display();
        digit_entry_keeps_two();
        addition_result();
        multiplication_results();
        ignored_and_clear_keys();
        fresh_entry_after_result();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam real HALF_PERIOD = 50.0;  // 100 ns period

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

/* hdl/bin_to_bcd.sv */
`timescale 1ns/1ps

module bin_to_bcd
    import calc_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  show_t show,
    output bcd_t  digits
);

    localparam int BCD_W = $bits(bcd_t);

    logic [BCD_W+VALUE_BITS-1:0] sreg;      // BCD field on top of the binary
    logic [BCD_W+VALUE_BITS-1:0] sreg_adj;
    logic [BCD_CNT_BITS-1:0]     cnt;
    logic                        busy;

    // Add 3 to any nibble of 5 or more
    always_comb begin
        sreg_adj = sreg;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (sreg_adj[VALUE_BITS + 4*i +: 4] >= 4'd5) begin
                sreg_adj[VALUE_BITS + 4*i +: 4] = sreg_adj[VALUE_BITS + 4*i +: 4] + 4'd3;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            cnt    <= '0;
            digits <= '0;
        end else if (show.valid) begin  // Restart and drop any conversion
            busy <= 1'b1;
            cnt  <= BCD_CNT_BITS'(VALUE_BITS);
        end else if (busy) begin
            if (cnt == '0) begin
                digits <= bcd_t'(sreg[BCD_W+VALUE_BITS-1 -: BCD_W]);
                busy   <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (show.valid) begin
            sreg <= {{BCD_W{1'b0}}, show.value};
        end else if (busy && cnt != '0) begin
            sreg <= sreg_adj << 1;
        end
    end

endmodule

/* hdl/calc_execute.sv */
`timescale 1ns/1ps

module calc_execute
    import keypad_pkg::*;
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  key_evt_t key,
    input  value_t   product,
    input  logic     done,
    output logic     start,
    output operand_t a,
    output operand_t b,
    output show_t    show
);

    calc_state_e state;
    op_e         op;
    operand_t    entry;
    logic        is_digit;
    logic        show_valid;
    value_t      show_value;

    // Keep only the last two digits typed
    function automatic operand_t next_operand(operand_t old, key_code_t digit);
        operand_t ones;
        ones = operand_t'(old % 10);
        return operand_t'(ones * 10 + digit);
    endfunction

    assign is_digit = (key.code <= 4'd9);

    always_comb begin
        case (state)
            ENTER_B: entry = next_operand(b, key.code);
            RESULT:  entry = operand_t'(key.code);  // Fresh start after a result
            default: entry = next_operand(a, key.code);
        endcase
    end

    // ******************************
    // Entry FSM
    // ******************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ENTER_A;
            op         <= OP_ADD;
            a          <= '0;
            b          <= '0;
            start      <= 1'b0;
            show_valid <= 1'b0;
            show_value <= '0;
        end else begin
            start      <= 1'b0;
            show_valid <= 1'b0;
            if (state == BUSY) begin
                if (done) begin  // Keys are dropped while waiting
                    show_valid <= 1'b1;
                    show_value <= product;
                    state      <= RESULT;
                end
            end else if (key.valid) begin
                if (is_digit) begin
                    show_valid <= 1'b1;
                    show_value <= value_t'(entry);
                    if (state == ENTER_B) begin
                        b <= entry;
                    end else begin
                        a     <= entry;
                        state <= ENTER_A;
                    end
                end else if (key.code == KEY_CLR) begin
                    a          <= '0;
                    b          <= '0;
                    show_valid <= 1'b1;
                    show_value <= '0;
                    state      <= ENTER_A;
                end else if ((key.code == KEY_ADD || key.code == KEY_MUL) &&
                             state == ENTER_A) begin
                    op    <= (key.code == KEY_MUL) ? OP_MUL : OP_ADD;
                    b     <= '0;  // Display keeps A
                    state <= ENTER_B;
                end else if (key.code == KEY_EQ && state == ENTER_B) begin
                    if (op == OP_MUL) begin
                        start <= 1'b1;
                        state <= BUSY;
                    end else begin
                        show_valid <= 1'b1;
                        show_value <= value_t'(a) + value_t'(b);
                        state      <= RESULT;
                    end
                end
            end
        end
    end

    assign show = '{valid: show_valid, value: show_value};

endmodule

/* hdl/calc_pkg.sv */
package calc_pkg;

    // ******************************
    // Widths and timing
    // ******************************
    localparam int OPERAND_BITS      = 7;   // 0..99
    localparam int VALUE_BITS        = 14;  // 0..9801
    localparam int NUM_DIGITS        = 4;
    localparam int DIGIT_TICK_CYCLES = 4;   // Clocks per lit digit

    localparam int MULT_CNT_BITS   = $clog2(OPERAND_BITS + 1);
    localparam int BCD_CNT_BITS    = $clog2(VALUE_BITS + 1);
    localparam int DIGIT_TICK_BITS = $clog2(DIGIT_TICK_CYCLES);
    localparam int DIGIT_SEL_BITS  = $clog2(NUM_DIGITS);

    // ******************************
    // Data types
    // ******************************
    typedef logic [OPERAND_BITS-1:0] operand_t;
    typedef logic [VALUE_BITS-1:0]   value_t;
    typedef logic [3:0]              bcd_digit_t;
    typedef logic [6:0]              seg_t;    // gfedcba, active low
    typedef logic [NUM_DIGITS-1:0]   anode_t;  // Active low

    typedef struct packed {
        bcd_digit_t thousands;
        bcd_digit_t hundreds;
        bcd_digit_t tens;
        bcd_digit_t ones;
    } bcd_t;

    typedef struct packed {
        logic   valid;
        value_t value;
    } show_t;

    typedef enum logic {OP_ADD, OP_MUL} op_e;

    typedef enum logic [1:0] {ENTER_A, ENTER_B, BUSY, RESULT} calc_state_e;

    // Segment patterns for 0..9
    localparam seg_t SEG_PATTERNS [10] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0011000
    };

endpackage

/* hdl/key_decode.sv */
`timescale 1ns/1ps

module key_decode
    import keypad_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  col_t     cols,
    output row_t     rows,
    output key_evt_t key
);

    col_t                       cols_meta;
    col_t                       cols_sync;
    logic [SCAN_CNT_BITS-1:0]   tick_cnt;
    logic                       tick_end;
    logic                       rev_end;
    logic                       hit;
    key_code_t                  hit_code;
    logic                       seen_valid;
    key_code_t                  seen_code;
    logic                       rev_valid;
    key_code_t                  rev_code;
    key_code_t                  last_code;
    logic [STABLE_CNT_BITS-1:0] stable_cnt;
    logic [STABLE_CNT_BITS-1:0] stable_next;
    logic                       locked;
    logic                       fire;
    logic                       key_valid;
    key_code_t                  key_code;

    // Columns come straight off the pins
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cols_meta <= '0;
            cols_sync <= '0;
        end else begin
            cols_meta <= cols;
            cols_sync <= cols_meta;
        end
    end

    assign tick_end = (tick_cnt == SCAN_CNT_BITS'(SCAN_TICK_CYCLES - 1));
    assign rev_end  = tick_end && rows[3];  // Last row of a revolution

    // Lowest column wins, so it is visited last
    always_comb begin
        hit      = 1'b0;
        hit_code = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 3; c >= 0; c--) begin
                if (rows[r] && cols_sync[c]) begin
                    hit      = 1'b1;
                    hit_code = KEY_LAYOUT[r][c];
                end
            end
        end
    end

    // ******************************
    // Per-revolution debounce
    // ******************************
    assign rev_valid = seen_valid || hit;
    assign rev_code  = seen_valid ? seen_code : hit_code;  // First row seen wins

    always_comb begin
        if (!rev_valid) begin
            stable_next = '0;
        end else if (stable_cnt != '0 && rev_code == last_code) begin
            stable_next = (stable_cnt == STABLE_CNT_BITS'(KEY_STABLE_SCANS)) ?
                          stable_cnt : stable_cnt + 1'b1;  // Saturate
        end else begin
            stable_next = STABLE_CNT_BITS'(1);  // New key starts over
        end
    end

    assign fire = rev_end && rev_valid && !locked &&
                  (stable_next == STABLE_CNT_BITS'(KEY_STABLE_SCANS));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt   <= '0;
            rows       <= row_t'(1);
            seen_valid <= 1'b0;
            stable_cnt <= '0;
            locked     <= 1'b0;
            key_valid  <= 1'b0;
        end else begin
            key_valid <= fire;
            tick_cnt  <= tick_end ? '0 : tick_cnt + 1'b1;
            if (tick_end) begin
                rows <= {rows[2:0], rows[3]};
            end
            if (rev_end) begin
                seen_valid <= 1'b0;
                stable_cnt <= stable_next;
                if (!rev_valid) begin
                    locked <= 1'b0;  // Released for a full revolution
                end else if (fire) begin
                    locked <= 1'b1;
                end
            end else if (tick_end && hit) begin
                seen_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tick_end && hit && !seen_valid) begin
            seen_code <= hit_code;
        end
        if (rev_end && rev_valid) begin
            last_code <= rev_code;
        end
        if (rev_end) begin
            key_code <= rev_code;
        end
    end

    assign key = '{valid: key_valid, code: key_code};

endmodule

/* hdl/keypad_calc.sv */
`timescale 1ns/1ps

module keypad_calc
    import keypad_pkg::*;
    import calc_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  col_t   cols,
    output row_t   rows,
    output seg_t   seg,
    output anode_t an
);

    key_evt_t key;
    logic     start;
    logic     done;
    operand_t a;
    operand_t b;
    value_t   product;
    show_t    show;
    bcd_t     digits;

    // ******************************
    // Decode
    // ******************************
    key_decode i_key_decode (
        .clk  (clk),
        .rst  (rst),
        .cols (cols),
        .rows (rows),
        .key  (key)
    );

    // ******************************
    // Execute
    // ******************************
    calc_execute i_calc_execute (
        .clk     (clk),
        .rst     (rst),
        .key     (key),
        .product (product),
        .done    (done),
        .start   (start),
        .a       (a),
        .b       (b),
        .show    (show)
    );

    shift_add_mult i_shift_add_mult (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .a       (a),
        .b       (b),
        .product (product),
        .done    (done)
    );

    // ******************************
    // Result
    // ******************************
    bin_to_bcd i_bin_to_bcd (
        .clk    (clk),
        .rst    (rst),
        .show   (show),
        .digits (digits)
    );

    seg_scan i_seg_scan (
        .clk    (clk),
        .rst    (rst),
        .digits (digits),
        .seg    (seg),
        .an     (an)
    );

endmodule

/* hdl/keypad_pkg.sv */
package keypad_pkg;

    // ******************************
    // Keypad types
    // ******************************
    typedef logic [3:0] row_t;       // One-hot row drive, active high
    typedef logic [3:0] col_t;       // Column sense, active high
    typedef logic [3:0] key_code_t;  // Digits 0-9, letters A-F as 10-15

    typedef struct packed {
        logic      valid;
        key_code_t code;
    } key_evt_t;

    // Function keys
    localparam key_code_t KEY_ADD = 4'd10;  // A
    localparam key_code_t KEY_MUL = 4'd11;  // B
    localparam key_code_t KEY_EQ  = 4'd12;  // C
    localparam key_code_t KEY_CLR = 4'd13;  // D

    // Layout indexed by [row][column]
    localparam key_code_t KEY_LAYOUT [4][4] = '{
        '{4'd1,  4'd2, 4'd3,  KEY_ADD},
        '{4'd4,  4'd5, 4'd6,  KEY_MUL},
        '{4'd7,  4'd8, 4'd9,  KEY_EQ},
        '{4'd14, 4'd0, 4'd15, KEY_CLR}
    };

    // ******************************
    // Scan timing sized for simulation
    // ******************************
    localparam int SCAN_TICK_CYCLES = 8;   // Clocks per row step
    localparam int KEY_STABLE_SCANS = 2;   // Revolutions before accept
    localparam int SCAN_CNT_BITS    = $clog2(SCAN_TICK_CYCLES);
    localparam int STABLE_CNT_BITS  = $clog2(KEY_STABLE_SCANS + 1);

endpackage

/* hdl/seg_scan.sv */
`timescale 1ns/1ps

module seg_scan
    import calc_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  bcd_t   digits,
    output seg_t   seg,
    output anode_t an
);

    logic [DIGIT_TICK_BITS-1:0] tick_cnt;
    logic                       tick_end;
    logic [DIGIT_SEL_BITS-1:0]  sel;  // 0 is ones
    logic                       lit;  // Set after first tick
    bcd_digit_t                 cur;

    assign tick_end = (tick_cnt == DIGIT_TICK_BITS'(DIGIT_TICK_CYCLES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
            sel      <= '0;
            lit      <= 1'b0;
        end else begin
            tick_cnt <= tick_end ? '0 : tick_cnt + 1'b1;
            if (tick_end) begin
                lit <= 1'b1;
                if (lit) begin
                    sel <= sel + 1'b1;  // Ones up to thousands, then wrap
                end
            end
        end
    end

    // ******************************
    // Digit select and decode
    // ******************************
    always_comb begin
        case (sel)
            2'd0:    cur = digits.ones;
            2'd1:    cur = digits.tens;
            2'd2:    cur = digits.hundreds;
            default: cur = digits.thousands;
        endcase
    end

    always_comb begin
        seg = '1;  // Blank
        if (cur <= 4'd9) begin
            seg = SEG_PATTERNS[cur];
        end
    end

    assign an = lit ? ~(anode_t'(1) << sel) : '1;

endmodule

/* hdl/shift_add_mult.sv */
`timescale 1ns/1ps

module shift_add_mult
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  operand_t a,
    input  operand_t b,
    output value_t   product,
    output logic     done
);

    value_t                   mcand;   // Shifted multiplicand
    operand_t                 mplier;  // Consumed LSB first
    value_t                   acc;
    value_t                   addend;
    logic [MULT_CNT_BITS-1:0] cnt;
    logic                     busy;

    assign addend = mplier[0] ? mcand : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= MULT_CNT_BITS'(OPERAND_BITS);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == MULT_CNT_BITS'(1)) begin  // Last bit this cycle
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= value_t'(a);
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc + addend;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (cnt == MULT_CNT_BITS'(1)) begin
                product <= acc + addend;
            end
        end
    end

endmodule

/* src.f */
hdl/keypad_pkg.sv
hdl/calc_pkg.sv
hdl/key_decode.sv
hdl/calc_execute.sv
hdl/shift_add_mult.sv
hdl/bin_to_bcd.sv
hdl/seg_scan.sv
hdl/keypad_calc.sv
bench/tb_clock.sv
bench/keypad_calc_tb.sv
